//--- Bender.yml
package:
  name: ctrl_core

sources:
  - ctrl_pkg.sv
  - ctrl_fsm.sv
  - ctrl_hazard.sv
  - ctrl_forward.sv
  - ctrl_top.sv
  - target: test
    files:
      - tb_ctrl_top.sv

//--- ctrl_forward.sv
// core controller operand forwarding select for the three register operands
`timescale 1ns/1ps

module ctrl_forward import ctrl_pkg::*;
(
  input  wr_port_t   wr_i,
  input  reg_match_t match_i,
  input  logic       data_misaligned_i,
  input  logic       mult_multicycle_i,

  output fw_sel_t    fw_sel_o
);

  // per operand choice, ex path beats wb path beats regfile
  function automatic fw_sel_e pick_src(input logic wb_hit, input logic ex_hit);
    fw_sel_e src;
    src = SEL_REGFILE;
    if (wb_hit)
      src = SEL_FW_WB;
    if (ex_hit)
      src = SEL_FW_EX;
    return src;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // operand mux selects
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    // normal bypass from the wb and alu paths
    fw_sel_o.sel_a = pick_src(wr_i.wb_we & match_i.wb_a, wr_i.alu_we & match_i.alu_a);
    fw_sel_o.sel_b = pick_src(wr_i.wb_we & match_i.wb_b, wr_i.alu_we & match_i.alu_b);
    fw_sel_o.sel_c = pick_src(wr_i.wb_we & match_i.wb_c, wr_i.alu_we & match_i.alu_c);

    if (data_misaligned_i)
    begin
      // second access of a split load/store
      // a takes the incremented address from ex, b the plain offset
      fw_sel_o.sel_a = SEL_FW_EX;
      fw_sel_o.sel_b = SEL_REGFILE;
    end
    else if (mult_multicycle_i)
    begin
      // multicycle multiply keeps its partial result on operand c
      fw_sel_o.sel_c = SEL_FW_EX;
    end
  end

endmodule

//--- ctrl_fsm.sv
// core controller sequencing fsm for boot, decode redirects, exceptions, flush and sleep
`timescale 1ns/1ps

module ctrl_fsm import ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // core start and decoder flags
  input  logic       fetch_enable_i,
  input  logic       eret_insn_i,
  input  logic       pipe_flush_i,
  input  logic       instr_valid_i,
  input  logic       branch_taken_ex_i,
  input  jump_kind_e jump_in_dec_i,

  // exception controller request
  input  logic       exc_req_i,

  // pipeline progress and stall from the hazard unit
  input  logic       id_ready_i,
  input  logic       ex_valid_i,
  input  logic       jr_stall_i,

  output logic       ctrl_busy_o,
  output logic       is_decoding_o,

  // fetch control
  output logic       instr_req_o,
  output logic       pc_set_o,
  output pc_mux_e    pc_mux_o,

  // exception strobes
  output logic       exc_ack_o,
  output logic       exc_save_if_o,
  output logic       exc_save_id_o,
  output logic       exc_restore_id_o,

  output logic       halt_if_o,
  output logic       halt_id_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // set once a jump or eret redirect went out, held until id accepts
  logic jump_done_q;
  logic jump_done_d;

  // unconditional jump sitting in decode
  logic is_jump;

  assign is_jump = (jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR);

  //////////////////////////////////////////////////////////////////////
  // next state and output decode
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    // defaults, core running and fetching
    instr_req_o      = 1'b1;
    ctrl_busy_o      = 1'b1;
    is_decoding_o    = 1'b0;
    pc_set_o         = 1'b0;
    pc_mux_o         = PC_BOOT;
    exc_ack_o        = 1'b0;
    exc_save_if_o    = 1'b0;
    exc_save_id_o    = 1'b0;
    exc_restore_id_o = 1'b0;
    halt_if_o        = 1'b0;
    halt_id_o        = 1'b0;
    jump_done_d      = jump_done_q;
    state_d          = state_q;

    case (state_q)
      // idle until fetch enable arrives
      RESET:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i)
          state_d = BOOT_SET;
      end

      // one cycle load of the boot address
      BOOT_SET:
      begin
        pc_mux_o = PC_BOOT;
        pc_set_o = 1'b1;
        state_d  = FIRST_FETCH;
      end

      // clock gated region, woken by enable or exception
      SLEEP:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || exc_req_i)
          state_d = FIRST_FETCH;
      end

      // wait for the first instruction to reach id
      FIRST_FETCH:
      begin
        if (id_ready_i)
          state_d = DECODE;

        // pending exception after wake-up, if stage pc is saved
        if (exc_req_i)
        begin
          pc_mux_o      = PC_EXCEPTION;
          pc_set_o      = 1'b1;
          exc_ack_o     = 1'b1;
          exc_save_if_o = 1'b1;
        end
      end

      DECODE:
      begin
        // id instruction only counts when no taken branch sits in ex
        if (instr_valid_i && !branch_taken_ex_i)
        begin
          is_decoding_o = 1'b1;

          if (is_jump)
          begin
            // target known in decode, redirect once jr hazard clears
            pc_mux_o = PC_JUMP;
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end
          else if (exc_req_i)
          begin
            // take the exception and keep the id instruction out of ex
            pc_mux_o      = PC_EXCEPTION;
            pc_set_o      = 1'b1;
            exc_ack_o     = 1'b1;
            halt_id_o     = 1'b1;
            exc_save_id_o = 1'b1;
          end

          // eret wins the pc source over jump and exception
          if (eret_insn_i)
          begin
            pc_mux_o         = PC_ERET;
            exc_restore_id_o = 1'b1;
            if (!jump_done_q)
            begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end

          // wfi style flush, or eret back into sleep
          if (pipe_flush_i || (eret_insn_i && !fetch_enable_i))
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end

        // taken branch in ex overrides everything decoded above
        if (branch_taken_ex_i)
        begin
          pc_mux_o      = PC_BRANCH;
          pc_set_o      = 1'b1;
          is_decoding_o = 1'b0;
        end
      end

      // drain ex, nop into ex
      FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i)
          state_d = FLUSH_WB;
      end

      // drain wb, then resume or sleep
      FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i)
        begin
          state_d   = DECODE;
          halt_if_o = 1'b0;
        end
        else
        begin
          state_d = SLEEP;
        end
      end

      // unused encoding, fall back to reset
      default:
      begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // state registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // id accepted the next instruction, allow a new redirect
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

endmodule

//--- ctrl_hazard.sv
// core controller hazard unit for load-use and jump-register stalls and write-enable kill
`timescale 1ns/1ps

module ctrl_hazard import ctrl_pkg::*;
#(
  parameter int unsigned REG_ADDR_W = ctrl_pkg::REG_ADDR_W
)
(
  input  wr_port_t   wr_i,
  input  reg_match_t match_i,
  input  logic       data_req_ex_i,
  input  jump_kind_e jump_in_dec_i,
  input  logic       is_decoding_i,
  input  logic       illegal_insn_i,

  output logic       load_stall_o,
  output logic       jr_stall_o,
  output logic       deassert_we_o
);

  // rv32e up to a combined int and fp file
  if ((REG_ADDR_W < 4) || (REG_ADDR_W > 6))
  begin : g_bad_width
    $error("register address width out of range");
  end

  // ex holds a writer of any operand of the id instruction
  logic ex_hit;
  // some path still has to produce the jalr base register
  logic jr_base_busy;

  //////////////////////////////////////////////////////////////////////
  // stall detection
  //////////////////////////////////////////////////////////////////////

  assign ex_hit = wr_i.ex_we & (match_i.ex_a | match_i.ex_b | match_i.ex_c);

  // load data only arrives in wb, no bypass from ex possible
  assign load_stall_o = data_req_ex_i & ex_hit;

  assign jr_base_busy = (wr_i.wb_we  & match_i.wb_a) |
                        (wr_i.ex_we  & match_i.ex_a) |
                        (wr_i.alu_we & match_i.alu_a);

  // the jump target is computed in id, so any pending writer blocks it
  assign jr_stall_o = (jump_in_dec_i == BRANCH_JALR) & jr_base_busy;

  //////////////////////////////////////////////////////////////////////
  // write-enable suppression
  //////////////////////////////////////////////////////////////////////

  // no commit outside decode, on illegal opcodes or while stalled
  assign deassert_we_o = ~is_decoding_i | illegal_insn_i | load_stall_o | jr_stall_o;

endmodule

//--- ctrl_pkg.sv
// core controller shared types, state encoding and default widths
package ctrl_pkg;

  // default register file address width (32 registers)
  localparam int unsigned REG_ADDR_W = 5;

  //////////////////////////////////////////////////////////////////////
  // encodings toward fetch and from the decoder
  //////////////////////////////////////////////////////////////////////

  // pc source selector toward the fetch stage
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101
  } pc_mux_e;

  // jump class of the instruction in decode
  typedef enum logic [1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    BRANCH_COND = 2'b11
  } jump_kind_e;

  // operand source, regfile or one of the two bypass paths
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

  // sequencing fsm states
  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH_EX,
    FLUSH_WB
  } ctrl_state_e;

  //////////////////////////////////////////////////////////////////////
  // bundles between pipeline and controller
  //////////////////////////////////////////////////////////////////////

  // write enables of the ex, wb and alu bypass paths
  typedef struct packed {
    logic ex_we;
    logic wb_we;
    logic alu_we;
  } wr_port_t;

  // destination of path equals operand a, b or c
  typedef struct packed {
    logic ex_a;
    logic ex_b;
    logic ex_c;
    logic wb_a;
    logic wb_b;
    logic wb_c;
    logic alu_a;
    logic alu_b;
    logic alu_c;
  } reg_match_t;

  // operand mux selects toward the id stage
  typedef struct packed {
    fw_sel_e sel_a;
    fw_sel_e sel_b;
    fw_sel_e sel_c;
  } fw_sel_t;

endpackage

//--- ctrl_top.sv
// core controller top level joining the sequencing fsm, hazard and forwarding units
`timescale 1ns/1ps

module ctrl_top import ctrl_pkg::*;
#(
  parameter int unsigned REG_ADDR_W = ctrl_pkg::REG_ADDR_W
)
(
  input  logic       clk,
  input  logic       rst_n,

  // start and decoder flags
  input  logic       fetch_enable_i,
  input  logic       eret_insn_i,
  input  logic       pipe_flush_i,
  input  logic       illegal_insn_i,
  input  logic       instr_valid_i,
  input  logic       branch_taken_ex_i,
  input  jump_kind_e jump_in_dec_i,

  // exception controller
  input  logic       exc_req_i,

  // pipeline progress
  input  logic       id_ready_i,
  input  logic       ex_valid_i,

  // lsu and multiplier state
  input  logic       data_req_ex_i,
  input  logic       data_misaligned_i,
  input  logic       mult_multicycle_i,

  // write ports and address compare results of the pipeline
  input  wr_port_t   wr_i,
  input  reg_match_t match_i,

  output logic       ctrl_busy_o,
  output logic       is_decoding_o,

  // fetch control
  output logic       instr_req_o,
  output logic       pc_set_o,
  output pc_mux_e    pc_mux_o,

  // exception strobes
  output logic       exc_ack_o,
  output logic       exc_save_if_o,
  output logic       exc_save_id_o,
  output logic       exc_restore_id_o,

  // pipeline stalls
  output logic       halt_if_o,
  output logic       halt_id_o,
  output logic       load_stall_o,
  output logic       jr_stall_o,
  output logic       deassert_we_o,

  // operand bypass selects
  output fw_sel_t    fw_sel_o
);

  //////////////////////////////////////////////////////////////////////
  // sequencing fsm, is_decoding out and jr_stall back in
  //////////////////////////////////////////////////////////////////////

  ctrl_fsm u_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .eret_insn_i       (eret_insn_i),
    .pipe_flush_i      (pipe_flush_i),
    .instr_valid_i     (instr_valid_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .jump_in_dec_i     (jump_in_dec_i),
    .exc_req_i         (exc_req_i),
    .id_ready_i        (id_ready_i),
    .ex_valid_i        (ex_valid_i),
    .jr_stall_i        (jr_stall_o),
    .ctrl_busy_o       (ctrl_busy_o),
    .is_decoding_o     (is_decoding_o),
    .instr_req_o       (instr_req_o),
    .pc_set_o          (pc_set_o),
    .pc_mux_o          (pc_mux_o),
    .exc_ack_o         (exc_ack_o),
    .exc_save_if_o     (exc_save_if_o),
    .exc_save_id_o     (exc_save_id_o),
    .exc_restore_id_o  (exc_restore_id_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o)
  );

  // stall detection, needs the decode qualifier from the fsm
  ctrl_hazard #(
    .REG_ADDR_W (REG_ADDR_W)
  ) u_hazard (
    .wr_i           (wr_i),
    .match_i        (match_i),
    .data_req_ex_i  (data_req_ex_i),
    .jump_in_dec_i  (jump_in_dec_i),
    .is_decoding_i  (is_decoding_o),
    .illegal_insn_i (illegal_insn_i),
    .load_stall_o   (load_stall_o),
    .jr_stall_o     (jr_stall_o),
    .deassert_we_o  (deassert_we_o)
  );

  // operand bypass selection
  ctrl_forward u_forward (
    .wr_i              (wr_i),
    .match_i           (match_i),
    .data_misaligned_i (data_misaligned_i),
    .mult_multicycle_i (mult_multicycle_i),
    .fw_sel_o          (fw_sel_o)
  );

endmodule

//--- tb_ctrl_top.sv
// random testbench for the core controller with a cycle-level reference model
`timescale 1ns/1ps

module tb_ctrl_top import ctrl_pkg::*; ();

  // about 3900 cycles of tests plus margin
  localparam int unsigned CYCLE_LIMIT = 6000;
  localparam int unsigned FLUSH_ROUNDS = 40;

  logic clk;
  logic rst_n;
  integer seed;
  int unsigned cycle_cnt;
  int unsigned n_checks;
  int unsigned n_errors;
  int unsigned boot_sets;

  // dut inputs
  logic fetch_enable, eret_insn, pipe_flush, illegal_insn;
  logic instr_valid, branch_taken, exc_req, id_ready, ex_valid;
  logic data_req_ex, data_misaligned, mult_multicycle;
  jump_kind_e jump_in_dec;
  wr_port_t wr;
  reg_match_t match;

  // dut outputs
  logic busy, is_decoding, instr_req, pc_set;
  logic exc_ack, save_if, save_id, restore_id;
  logic halt_if, halt_id, load_stall, jr_stall, deassert_we;
  pc_mux_e pc_mux;
  fw_sel_t fw_sel;

  // reference model state and expected values
  ctrl_state_e m_state, n_state;
  logic m_jump_done, n_jump_done;
  logic e_busy, e_dec, e_req, e_pcset, e_ack, e_save_if, e_save_id, e_restore;
  logic e_halt_if, e_halt_id, e_load, e_jr, e_dwe;
  pc_mux_e e_mux;
  fw_sel_t e_fw;

  // dut outputs as seen at the last sample point
  logic s_pc_set, s_exc_ack;
  pc_mux_e s_pc_mux;

  ctrl_top #(
    .REG_ADDR_W (REG_ADDR_W)
  ) DUT (
    .clk (clk), .rst_n (rst_n),
    .fetch_enable_i (fetch_enable), .eret_insn_i (eret_insn), .pipe_flush_i (pipe_flush),
    .illegal_insn_i (illegal_insn), .instr_valid_i (instr_valid),
    .branch_taken_ex_i (branch_taken), .jump_in_dec_i (jump_in_dec), .exc_req_i (exc_req),
    .id_ready_i (id_ready), .ex_valid_i (ex_valid), .data_req_ex_i (data_req_ex),
    .data_misaligned_i (data_misaligned), .mult_multicycle_i (mult_multicycle),
    .wr_i (wr), .match_i (match), .ctrl_busy_o (busy), .is_decoding_o (is_decoding),
    .instr_req_o (instr_req), .pc_set_o (pc_set), .pc_mux_o (pc_mux),
    .exc_ack_o (exc_ack), .exc_save_if_o (save_if), .exc_save_id_o (save_id),
    .exc_restore_id_o (restore_id), .halt_if_o (halt_if), .halt_id_o (halt_id),
    .load_stall_o (load_stall), .jr_stall_o (jr_stall), .deassert_we_o (deassert_we),
    .fw_sel_o (fw_sel)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // hang guard counting edges from time zero
  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("run hung, cycle limit of %0d reached before the tests ended", CYCLE_LIMIT);
    $display("Test failed");
    $finish;
  end

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("ERROR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////

  task automatic model_eval();
    logic [2:0] wb_hit;
    logic [2:0] alu_hit;
    fw_sel_e sel [3];
    logic uncond;
    int k;
    // bit 2 is operand a, bit 0 operand c
    wb_hit  = {match.wb_a, match.wb_b, match.wb_c} & {3{wr.wb_we}};
    alu_hit = {match.alu_a, match.alu_b, match.alu_c} & {3{wr.alu_we}};
    for (k = 0; k < 3; k++)
      sel[k] = alu_hit[k] ? SEL_FW_EX : (wb_hit[k] ? SEL_FW_WB : SEL_REGFILE);
    if (data_misaligned)
    begin
      sel[2] = SEL_FW_EX;
      sel[1] = SEL_REGFILE;
    end
    else if (mult_multicycle)
      sel[0] = SEL_FW_EX;
    e_fw = '{sel_a: sel[2], sel_b: sel[1], sel_c: sel[0]};

    // stall terms do not depend on the fsm
    e_load = data_req_ex & wr.ex_we & (match.ex_a | match.ex_b | match.ex_c);
    e_jr   = (jump_in_dec == BRANCH_JALR) &
             ((wr.wb_we & match.wb_a) | (wr.ex_we & match.ex_a) | (wr.alu_we & match.alu_a));

    {e_dec, e_pcset, e_ack, e_save_if, e_save_id, e_restore, e_halt_if, e_halt_id} = '0;
    e_busy      = 1'b1;
    e_req       = 1'b1;
    e_mux       = PC_BOOT;
    n_state     = m_state;
    n_jump_done = m_jump_done;
    uncond      = (jump_in_dec == BRANCH_JAL) || (jump_in_dec == BRANCH_JALR);

    case (m_state)
      RESET:
      begin
        {e_busy, e_req} = 2'b00;
        if (fetch_enable)
          n_state = BOOT_SET;
      end
      BOOT_SET:
      begin
        e_pcset = 1'b1;
        n_state = FIRST_FETCH;
      end
      SLEEP:
      begin
        {e_busy, e_req, e_halt_if, e_halt_id} = 4'b0011;
        if (fetch_enable || exc_req)
          n_state = FIRST_FETCH;
      end
      FIRST_FETCH:
      begin
        if (id_ready)
          n_state = DECODE;
        if (exc_req)
        begin
          {e_pcset, e_ack, e_save_if} = 3'b111;
          e_mux = PC_EXCEPTION;
        end
      end
      DECODE:
      begin
        if (branch_taken)
        begin
          e_pcset = 1'b1;
          e_mux   = PC_BRANCH;
        end
        else if (instr_valid)
        begin
          e_dec = 1'b1;
          if (uncond)
          begin
            e_mux = PC_JUMP;
            // redirect held while the base register is pending
            if (!e_jr && !m_jump_done)
              {e_pcset, n_jump_done} = 2'b11;
          end
          else if (exc_req)
          begin
            {e_pcset, e_ack, e_halt_id, e_save_id} = 4'b1111;
            e_mux = PC_EXCEPTION;
          end
          if (eret_insn)
          begin
            e_mux     = PC_ERET;
            e_restore = 1'b1;
            if (!m_jump_done)
              {e_pcset, n_jump_done} = 2'b11;
          end
          if (pipe_flush || (eret_insn && !fetch_enable))
          begin
            {e_halt_if, e_halt_id} = 2'b11;
            n_state = FLUSH_EX;
          end
        end
      end
      FLUSH_EX:
      begin
        {e_halt_if, e_halt_id} = 2'b11;
        if (ex_valid)
          n_state = FLUSH_WB;
      end
      default:
      begin
        // flush wb resumes with fetch enable and sleeps otherwise
        e_halt_id = 1'b1;
        e_halt_if = !fetch_enable;
        n_state   = fetch_enable ? DECODE : SLEEP;
      end
    endcase
    n_jump_done = n_jump_done & ~id_ready;
    e_dwe = ~e_dec | illegal_insn | e_load | e_jr;
  endtask

  task automatic compare_outputs();
    check_val("ctrl_busy_o", busy, e_busy);
    check_val("is_decoding_o", is_decoding, e_dec);
    check_val("instr_req_o", instr_req, e_req);
    check_val("pc_set_o", pc_set, e_pcset);
    // the selector only matters while a redirect is issued
    if (e_pcset)
      check_val("pc_mux_o", pc_mux, e_mux);
    check_val("exc_ack_o", exc_ack, e_ack);
    check_val("exc_save_if_o", save_if, e_save_if);
    check_val("exc_save_id_o", save_id, e_save_id);
    check_val("exc_restore_id_o", restore_id, e_restore);
    check_val("halt_if_o", halt_if, e_halt_if);
    check_val("halt_id_o", halt_id, e_halt_id);
    check_val("load_stall_o", load_stall, e_load);
    check_val("jr_stall_o", jr_stall, e_jr);
    check_val("deassert_we_o", deassert_we, e_dwe);
    check_val("fw_sel_o.sel_a", fw_sel.sel_a, e_fw.sel_a);
    check_val("fw_sel_o.sel_b", fw_sel.sel_b, e_fw.sel_b);
    check_val("fw_sel_o.sel_c", fw_sel.sel_c, e_fw.sel_c);
    check_val("u_fsm.state_q", DUT.u_fsm.state_q, m_state);
  endtask

  // entered 1 ns after an edge with inputs set and returns 1 ns after the next edge
  task automatic step_cycle();
    #2;
    model_eval();
    compare_outputs();
    s_pc_set  = pc_set;
    s_pc_mux  = pc_mux;
    s_exc_ack = exc_ack;
    if (pc_set && pc_mux == PC_BOOT)
      boot_sets++;
    @(posedge clk);
    m_state     = n_state;
    m_jump_done = n_jump_done;
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////

  task automatic rand_pipe();
    logic [31:0] r;
    r = rand_word();
    wr              = wr_port_t'(r[2:0]);
    match           = reg_match_t'(r[11:3]);
    data_req_ex     = r[12];
    data_misaligned = r[13] & r[14];
    mult_multicycle = r[15];
    illegal_insn    = r[16] & r[17] & r[18];
  endtask

  task automatic rand_decode();
    logic [31:0] r;
    r = rand_word();
    instr_valid  = r[0] | r[1];
    branch_taken = r[2] & r[3];
    jump_in_dec  = jump_kind_e'(r[5:4]);
    exc_req      = r[6] & r[7];
    eret_insn    = r[8] & r[9] & r[10];
    id_ready     = r[11];
    ex_valid     = r[12];
  endtask

  task automatic quiet_inputs();
    {eret_insn, pipe_flush, instr_valid, branch_taken, exc_req} = '0;
    jump_in_dec = BRANCH_NONE;
  endtask

  task automatic settle_in_decode();
    while (m_state != DECODE)
    begin
      quiet_inputs();
      {fetch_enable, ex_valid, id_ready} = 3'b111;
      step_cycle();
    end
  endtask

  task automatic report_test(input int id, input string name, input int unsigned err_start);
    $display("test %0d %s done, %0d mismatches", id, name, n_errors - err_start);
  endtask

  ////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////

  initial
  begin
    int unsigned err_start;
    int unsigned sleeps;
    int unsigned wakes;
    logic [31:0] r;
    logic fired;
    logic pending;
    seed = 90326;
    {n_checks, n_errors, boot_sets, sleeps, wakes} = '0;
    rst_n = 1'b0;
    {fetch_enable, illegal_insn, id_ready, ex_valid} = '0;
    {data_req_ex, data_misaligned, mult_multicycle} = '0;
    wr    = '0;
    match = '0;
    quiet_inputs();
    m_state     = RESET;
    m_jump_done = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // boot waits idle for fetch enable and then redirects once
    err_start = n_errors;
    repeat (4) step_cycle();
    fetch_enable = 1'b1;
    step_cycle();
    check_val("pc_set_o", s_pc_set, 1'b0);
    step_cycle();
    check_val("pc_set_o", s_pc_set, 1'b1);
    check_val("pc_mux_o", s_pc_mux, PC_BOOT);
    repeat (3) step_cycle();
    if (boot_sets != 1)
    begin
      n_errors++;
      $display("boot redirect seen %0d times instead of once", boot_sets);
    end
    report_test(1, "boot", err_start);

    // forwarding while the fsm waits in first fetch
    err_start = n_errors;
    repeat (1000)
    begin
      rand_pipe();
      step_cycle();
    end
    id_ready = 1'b1;
    step_cycle();
    report_test(2, "forwarding", err_start);

    // stalls in decode with no flush and no eret so the fsm stays put
    err_start = n_errors;
    repeat (1000)
    begin
      rand_pipe();
      rand_decode();
      eret_insn = 1'b0;
      step_cycle();
    end
    report_test(3, "stalls", err_start);

    // redirects in decode where eret without enable may detour through the flush states
    err_start = n_errors;
    pending   = 1'b0;
    repeat (1500)
    begin
      rand_pipe();
      rand_decode();
      r = rand_word();
      fetch_enable = (m_state != DECODE) | (|r[2:0]);
      step_cycle();
      fired = s_pc_set && (s_pc_mux == PC_JUMP);
      if (fired && pending)
      begin
        n_errors++;
        $display("jump redirect issued twice before id_ready at %0t", $time);
      end
      pending = (pending | fired) & ~id_ready;
    end
    report_test(4, "redirects", err_start);

    // flush rounds ending in decode or in sleep
    err_start = n_errors;
    for (int round = 0; round < FLUSH_ROUNDS; round++)
    begin
      settle_in_decode();
      quiet_inputs();
      {instr_valid, pipe_flush, fetch_enable} = 3'b111;
      step_cycle();
      pipe_flush = 1'b0;
      while (m_state == FLUSH_EX)
      begin
        r = rand_word();
        ex_valid = r[0];
        step_cycle();
      end
      r = rand_word();
      fetch_enable = r[0];
      step_cycle();
      if (m_state == SLEEP)
      begin
        sleeps++;
        fetch_enable = 1'b0;
        repeat (2) step_cycle();
        // wake by exception with or without enable
        exc_req      = 1'b1;
        fetch_enable = r[1];
        step_cycle();
        id_ready = 1'b0;
        step_cycle();
        check_val("pc_set_o", s_pc_set, 1'b1);
        check_val("pc_mux_o", s_pc_mux, PC_EXCEPTION);
        check_val("exc_ack_o", s_exc_ack, 1'b1);
        {exc_req, id_ready, fetch_enable} = 3'b011;
        step_cycle();
      end
      else
        wakes++;
    end
    if (sleeps == 0 || wakes == 0)
    begin
      n_errors++;
      $display("flush rounds never reached both sleep and decode");
    end
    report_test(5, "flush and sleep", err_start);

    $display("checks %0d, mismatches %0d, cycles %0d", n_checks, n_errors, cycle_cnt);
    if (n_errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- verilog.f
ctrl_pkg.sv
ctrl_fsm.sv
ctrl_hazard.sv
ctrl_forward.sv
ctrl_top.sv
tb_ctrl_top.sv
